//--- logic/ctrl_pkg.sv
package ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;

    // RV32I base opcodes
    localparam logic [OPCODE_W-1:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OPC_AUIPC  = 7'b0010111;

    // Access size for loads and stores
    localparam logic [FUNCT3_W-1:0] F3_BYTE   = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_HALF   = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_WORD   = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_BYTE_U = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_HALF_U = 3'b101;

    ////////////////////////////////////////////////////////////////////////////
    // Control encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_REG = 3'd0,
        ALU_IMM = 3'd1,
        LOAD    = 3'd2,
        STORE   = 3'd3,
        BRANCH  = 3'd4,
        JAL     = 3'd5,
        JALR    = 3'd6,
        NONE    = 3'd7     // Unsupported opcode
    } op_class_t;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_BRANCH = 2'b01,
        PC_JAL    = 2'b10,
        PC_JALR   = 2'b11
    } pc_sel_t;

    typedef enum logic [1:0] {
        WB_ALU = 2'b00,
        WB_MEM = 2'b01,
        WB_PC4 = 2'b10     // Return address
    } wb_sel_t;

    typedef enum logic [1:0] {
        SIZE_NONE = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } mem_size_t;

    // Datapath strobes and selects driven by an execute unit
    typedef struct packed {
        logic      pc_en;
        pc_sel_t   pc_select;
        logic      alu_src;    // High selects the immediate
        logic      reg_write;
        wb_sel_t   wb_sel;
        mem_size_t mem_size;
        logic      mem_read;
        logic      mem_write;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '{
        pc_en:     1'b0,
        pc_select: PC_PLUS4,
        alu_src:   1'b0,
        reg_write: 1'b0,
        wb_sel:    WB_ALU,
        mem_size:  SIZE_NONE,
        mem_read:  1'b0,
        mem_write: 1'b0
    };

endpackage

//--- logic/exec_if.sv
`timescale 1ns/1ps

// Start/done link between the sequencer and one execute unit
interface exec_if
    import ctrl_pkg::*;
();

    logic                start;       // One cycle, only while the unit is idle
    op_class_t           op_class;    // Held from start until done
    logic [FUNCT3_W-1:0] funct3;
    logic                done;        // One cycle per start
    ctrl_word_t          ctrl;        // Idle word while the unit is idle

    modport sequencer (
        output start,
        output op_class,
        output funct3,
        input  done,
        input  ctrl
    );

    modport unit (
        input  start,
        input  op_class,
        input  funct3,
        output done,
        output ctrl
    );

endinterface

//--- logic/main_sequencer.sv
`timescale 1ns/1ps

module main_sequencer
    import ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                go,
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [FUNCT3_W-1:0] funct3,
    exec_if.sequencer           alu_port,
    exec_if.sequencer           mem_port,
    exec_if.sequencer           xfer_port,
    output logic                ir_en,
    output ctrl_word_t          ctrl,
    output logic                instr_done,
    output logic                illegal
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_PC_INC,
        S_DISPATCH,
        S_WAIT,
        S_FINISH
    } seq_state_t;

    seq_state_t          state;
    seq_state_t          state_next;
    op_class_t           cls_now;     // Class of the opcode in the IR
    op_class_t           cls_q;
    logic [FUNCT3_W-1:0] funct3_q;
    logic                is_alu;
    logic                is_mem;
    logic                is_xfer;
    logic                unit_done;

    function automatic op_class_t classify(input logic [OPCODE_W-1:0] opc);
        op_class_t cls;
        case (opc)
            OPC_RTYPE:  cls = ALU_REG;
            OPC_ITYPE,
            OPC_LUI,
            OPC_AUIPC:  cls = ALU_IMM;    // Immediate operand on the ALU
            OPC_LOAD:   cls = LOAD;
            OPC_STORE:  cls = STORE;
            OPC_BRANCH: cls = BRANCH;
            OPC_JAL:    cls = JAL;
            OPC_JALR:   cls = JALR;
            default:    cls = NONE;
        endcase
        return cls;
    endfunction

    assign cls_now = classify(opcode);

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            cls_q <= NONE;
        end
        else
        begin
            state <= state_next;
            if (state == S_PC_INC)
            begin
                cls_q <= cls_now;    // Kept until the next fetch
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_PC_INC)
        begin
            funct3_q <= funct3;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            S_IDLE:     if (go) state_next = S_FETCH;
            S_FETCH:    state_next = S_PC_INC;
            // No unit to run for an unknown opcode
            S_PC_INC:   state_next = (cls_now == NONE) ? S_FINISH : S_DISPATCH;
            S_DISPATCH: state_next = S_WAIT;
            S_WAIT:     if (unit_done) state_next = S_FINISH;
            S_FINISH:   state_next = go ? S_FETCH : S_IDLE;
            default:    state_next = S_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Dispatch to the execute units
    ////////////////////////////////////////////////////////////////////////////

    assign is_alu  = cls_q inside {ALU_REG, ALU_IMM};
    assign is_mem  = cls_q inside {LOAD, STORE};
    assign is_xfer = cls_q inside {BRANCH, JAL, JALR};

    assign alu_port.start  = (state == S_DISPATCH) && is_alu;
    assign mem_port.start  = (state == S_DISPATCH) && is_mem;
    assign xfer_port.start = (state == S_DISPATCH) && is_xfer;

    assign alu_port.op_class  = cls_q;
    assign mem_port.op_class  = cls_q;
    assign xfer_port.op_class = cls_q;
    assign alu_port.funct3    = funct3_q;
    assign mem_port.funct3    = funct3_q;
    assign xfer_port.funct3   = funct3_q;

    assign unit_done = (is_alu && alu_port.done) || (is_mem && mem_port.done)
                       || (is_xfer && xfer_port.done);

    // Own word during the PC increment, else the running unit's word
    always_comb
    begin
        ctrl = CTRL_IDLE;
        if (state == S_PC_INC)
        begin
            ctrl.pc_en     = 1'b1;
            ctrl.pc_select = PC_PLUS4;
        end
        else if (state == S_WAIT)
        begin
            if (is_alu)
                ctrl = alu_port.ctrl;
            else if (is_mem)
                ctrl = mem_port.ctrl;
            else if (is_xfer)
                ctrl = xfer_port.ctrl;
        end
    end

    assign ir_en      = (state == S_FETCH);
    assign instr_done = (state == S_FINISH);
    assign illegal    = (state == S_FINISH) && (cls_q == NONE);

endmodule

//--- logic/alu_writeback_fsm.sv
`timescale 1ns/1ps

module alu_writeback_fsm
    import ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    exec_if.unit  port
);

    typedef enum logic {
        A_IDLE,
        A_WRITE
    } alu_state_t;

    alu_state_t state;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= A_IDLE;
        end
        else
        begin
            case (state)
                A_IDLE:  if (port.start) state <= A_WRITE;
                A_WRITE: state <= A_IDLE;    // Single write-back cycle
                default: state <= A_IDLE;
            endcase
        end
    end

    // Result goes straight from the ALU into the register file
    always_comb
    begin
        port.ctrl = CTRL_IDLE;
        port.done = 1'b0;
        if (state == A_WRITE)
        begin
            port.ctrl.reg_write = 1'b1;
            port.ctrl.wb_sel    = WB_ALU;
            port.ctrl.alu_src   = (port.op_class == ALU_IMM);
            port.done           = 1'b1;
        end
    end

endmodule

//--- logic/mem_access_fsm.sv
`timescale 1ns/1ps

module mem_access_fsm
    import ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    exec_if.unit  port
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_READ,      // Load address phase
        M_WB,        // Load data into the register file
        M_WRITE,     // Store
        M_SKIP       // funct3 without a size
    } mem_state_t;

    mem_state_t state;
    mem_size_t  size;

    always_comb
    begin
        case (port.funct3)
            F3_BYTE, F3_BYTE_U: size = SIZE_BYTE;
            F3_HALF, F3_HALF_U: size = SIZE_HALF;
            F3_WORD:            size = SIZE_WORD;
            default:            size = SIZE_NONE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= M_IDLE;
        end
        else
        begin
            case (state)
                M_IDLE:
                begin
                    if (port.start)
                    begin
                        if (size == SIZE_NONE)
                            state <= M_SKIP;
                        else if (port.op_class == LOAD)
                            state <= M_READ;
                        else if (port.op_class == STORE)
                            state <= M_WRITE;
                        else
                            state <= M_SKIP;
                    end
                end
                M_READ:  state <= M_WB;
                default: state <= M_IDLE;
            endcase
        end
    end

    always_comb
    begin
        port.ctrl = CTRL_IDLE;
        port.done = 1'b0;
        case (state)
            M_READ:
            begin
                port.ctrl.mem_read = 1'b1;
                port.ctrl.mem_size = size;
                port.ctrl.alu_src  = 1'b1;    // Base plus offset
            end
            M_WB:
            begin
                port.ctrl.reg_write = 1'b1;
                port.ctrl.wb_sel    = WB_MEM;
                port.ctrl.alu_src   = 1'b1;
                port.done           = 1'b1;
            end
            M_WRITE:
            begin
                port.ctrl.mem_write = 1'b1;
                port.ctrl.mem_size  = size;
                port.ctrl.alu_src   = 1'b1;
                port.done           = 1'b1;
            end
            M_SKIP:  port.done = 1'b1;    // Ends without a strobe
            default: port.done = 1'b0;
        endcase
    end

endmodule

//--- logic/control_transfer_fsm.sv
`timescale 1ns/1ps

module control_transfer_fsm
    import ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  comparator,
    exec_if.unit  port
);

    typedef enum logic {
        X_IDLE,
        X_ACTIVE
    } xfer_state_t;

    xfer_state_t state;
    logic        taken_q;    // Branch outcome seen at start

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= X_IDLE;
        end
        else
        begin
            case (state)
                X_IDLE:   if (port.start) state <= X_ACTIVE;
                X_ACTIVE: state <= X_IDLE;
                default:  state <= X_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (port.start)
        begin
            taken_q <= comparator;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Transfer cycle
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        port.ctrl = CTRL_IDLE;
        port.done = 1'b0;
        if (state == X_ACTIVE)
        begin
            port.done = 1'b1;
            case (port.op_class)
                BRANCH:
                begin
                    // Not taken leaves the PC at PC plus 4
                    if (taken_q)
                    begin
                        port.ctrl.pc_en     = 1'b1;
                        port.ctrl.pc_select = PC_BRANCH;
                    end
                end
                JAL:
                begin
                    port.ctrl.pc_en     = 1'b1;
                    port.ctrl.pc_select = PC_JAL;
                    port.ctrl.reg_write = 1'b1;
                    port.ctrl.wb_sel    = WB_PC4;    // Link register
                end
                JALR:
                begin
                    port.ctrl.pc_en     = 1'b1;
                    port.ctrl.pc_select = PC_JALR;
                    port.ctrl.reg_write = 1'b1;
                    port.ctrl.wb_sel    = WB_PC4;
                    port.ctrl.alu_src   = 1'b1;      // rs1 plus immediate
                end
                default: port.ctrl = CTRL_IDLE;
            endcase
        end
    end

endmodule

//--- logic/controller.sv
`timescale 1ns/1ps

module controller
    import ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                go,
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [FUNCT3_W-1:0] funct3,
    input  logic                comparator,    // Branch condition from the datapath
    output logic                ir_en,
    output logic                pc_en,
    output pc_sel_t             pc_select,
    output logic                alu_src,
    output logic                reg_write,
    output wb_sel_t             wb_sel,
    output mem_size_t           mem_size,
    output logic                mem_read,
    output logic                mem_write,
    output logic                instr_done,
    output logic                illegal
);

    ctrl_word_t ctrl_word;

    exec_if alu_bus ();
    exec_if mem_bus ();
    exec_if xfer_bus ();

    main_sequencer main_sequencer_inst (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .opcode     (opcode),
        .funct3     (funct3),
        .alu_port   (alu_bus.sequencer),
        .mem_port   (mem_bus.sequencer),
        .xfer_port  (xfer_bus.sequencer),
        .ir_en      (ir_en),
        .ctrl       (ctrl_word),
        .instr_done (instr_done),
        .illegal    (illegal)
    );

    alu_writeback_fsm alu_writeback_fsm_inst (
        .clk   (clk),
        .reset (reset),
        .port  (alu_bus.unit)
    );

    mem_access_fsm mem_access_fsm_inst (
        .clk   (clk),
        .reset (reset),
        .port  (mem_bus.unit)
    );

    control_transfer_fsm control_transfer_fsm_inst (
        .clk        (clk),
        .reset      (reset),
        .comparator (comparator),
        .port       (xfer_bus.unit)
    );

    // Datapath controls
    assign pc_en     = ctrl_word.pc_en;
    assign pc_select = ctrl_word.pc_select;
    assign alu_src   = ctrl_word.alu_src;
    assign reg_write = ctrl_word.reg_write;
    assign wb_sel    = ctrl_word.wb_sel;
    assign mem_size  = ctrl_word.mem_size;
    assign mem_read  = ctrl_word.mem_read;
    assign mem_write = ctrl_word.mem_write;

endmodule

//--- verification/controller_tb.sv
`timescale 1ns/1ps

module controller_tb
    import ctrl_pkg::*;
();

    localparam int DONE_TIMEOUT = 20;    // Cycles allowed for one instruction

    // One row of the stimulus table with its expected summary
    typedef struct {
        logic [OPCODE_W-1:0] opcode;
        logic [FUNCT3_W-1:0] funct3;
        logic                comparator;
        int                  n_reg_write;
        wb_sel_t             wb_sel;
        int                  n_mem_read;
        int                  n_mem_write;
        mem_size_t           mem_size;
        int                  n_pc_extra;     // pc_en cycles beyond the increment
        pc_sel_t             pc_select;
        logic                alu_src;
        logic                illegal;
        int                  cycles;         // Go sample to instr_done
    } test_entry_t;

    logic                clk;
    logic                reset;
    logic                go;
    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic                comparator;
    logic                ir_en;
    logic                pc_en;
    pc_sel_t             pc_select;
    logic                alu_src;
    logic                reg_write;
    wb_sel_t             wb_sel;
    mem_size_t           mem_size;
    logic                mem_read;
    logic                mem_write;
    logic                instr_done;
    logic                illegal;

    test_entry_t entries[$];
    int          error_count;
    int          timeout_count;
    int          cur_entry;

    // Monitor summary of one instruction
    logic      capture;
    logic      done_seen;
    int        cycle_cnt;
    int        n_ir_en;
    int        ir_cycle;
    int        n_pc_inc;
    int        inc_cycle;
    int        n_pc_extra;
    int        n_reg_write;
    int        n_mem_read;
    int        n_mem_write;
    int        n_stray_size;
    int        n_stray_illegal;
    int        latency;
    pc_sel_t   seen_pc_sel;
    wb_sel_t   seen_wb_sel;
    mem_size_t seen_size;
    logic      seen_alu_src;
    logic      illegal_at_done;

    controller controller_inst (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .opcode     (opcode),
        .funct3     (funct3),
        .comparator (comparator),
        .ir_en      (ir_en),
        .pc_en      (pc_en),
        .pc_select  (pc_select),
        .alu_src    (alu_src),
        .reg_write  (reg_write),
        .wb_sel     (wb_sel),
        .mem_size   (mem_size),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .instr_done (instr_done),
        .illegal    (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Monitor sampling on the falling edge

    always @(negedge clk)
    begin
        if (capture)
        begin
            cycle_cnt++;
            if (ir_en)
            begin
                n_ir_en++;
                ir_cycle = cycle_cnt;
            end
            if (pc_en && pc_select == PC_PLUS4)
            begin
                n_pc_inc++;
                inc_cycle = cycle_cnt;
            end
            else if (pc_en)
            begin
                n_pc_extra++;
                seen_pc_sel = pc_select;    // Branch or jump target
            end
            if (reg_write)
            begin
                n_reg_write++;
                seen_wb_sel = wb_sel;
            end
            if (mem_read)
                n_mem_read++;
            if (mem_write)
                n_mem_write++;
            if (mem_read || mem_write)
                seen_size = mem_size;
            else if (mem_size != SIZE_NONE)
                n_stray_size++;              // Size without a strobe
            seen_alu_src = seen_alu_src | alu_src;
            if (illegal && !instr_done)
                n_stray_illegal++;
            if (instr_done)
            begin
                done_seen       = 1'b1;
                latency         = cycle_cnt;
                illegal_at_done = illegal;
                capture         = 1'b0;
            end
        end
    end

    task automatic clear_monitor();
        done_seen       = 1'b0;
        cycle_cnt       = 0;
        n_ir_en         = 0;
        ir_cycle        = 0;
        n_pc_inc        = 0;
        inc_cycle       = 0;
        n_pc_extra      = 0;
        n_reg_write     = 0;
        n_mem_read      = 0;
        n_mem_write     = 0;
        n_stray_size    = 0;
        n_stray_illegal = 0;
        latency         = 0;
        seen_pc_sel     = PC_PLUS4;
        seen_wb_sel     = WB_ALU;
        seen_size       = SIZE_NONE;
        seen_alu_src    = 1'b0;
        illegal_at_done = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks

    function automatic string format_ctrl(input ctrl_word_t w);
        return {$sformatf("pc_en=%b pc_select=%0d alu_src=%b reg_write=%b",
                          w.pc_en, w.pc_select, w.alu_src, w.reg_write),
                $sformatf(" wb_sel=%0d size=%0d rd=%b wr=%b",
                          w.wb_sel, w.mem_size, w.mem_read, w.mem_write)};
    endfunction

    task automatic check_ctrl(input string what, input ctrl_word_t got, input ctrl_word_t exp);
        if (got !== exp)
        begin
            error_count++;
            $display("Mismatch at %0t: entry %0d %s got %s expected %s",
                     $time, cur_entry, what, format_ctrl(got), format_ctrl(exp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
        begin
            error_count++;
            $display("Mismatch at %0t: entry %0d %s got %0d expected %0d",
                     $time, cur_entry, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            error_count++;
            $display("Mismatch at %0t: entry %0d %s got %b expected %b",
                     $time, cur_entry, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table

    task automatic add_entry(input logic [OPCODE_W-1:0] opc, input logic [FUNCT3_W-1:0] f3,
                             input logic cmp, input int rw, input wb_sel_t wb, input int rd,
                             input int wr, input mem_size_t size, input int pc_extra,
                             input pc_sel_t psel, input logic src, input logic ill,
                             input int cycles);
        test_entry_t e;
        e.opcode      = opc;
        e.funct3      = f3;
        e.comparator  = cmp;
        e.n_reg_write = rw;
        e.wb_sel      = wb;
        e.n_mem_read  = rd;
        e.n_mem_write = wr;
        e.mem_size    = size;
        e.n_pc_extra  = pc_extra;
        e.pc_select   = psel;
        e.alu_src     = src;
        e.illegal     = ill;
        e.cycles      = cycles;
        entries.push_back(e);
    endtask

    task automatic build_table();
        // ALU write-back takes one unit cycle
        add_entry(OPC_RTYPE, 3'b000, 1'b0, 1, WB_ALU, 0, 0, SIZE_NONE, 0, PC_PLUS4, 1'b0, 1'b0, 5);
        add_entry(OPC_ITYPE, 3'b111, 1'b0, 1, WB_ALU, 0, 0, SIZE_NONE, 0, PC_PLUS4, 1'b1, 1'b0, 5);
        add_entry(OPC_LUI, 3'b010, 1'b0, 1, WB_ALU, 0, 0, SIZE_NONE, 0, PC_PLUS4, 1'b1, 1'b0, 5);
        add_entry(OPC_AUIPC, 3'b001, 1'b1, 1, WB_ALU, 0, 0, SIZE_NONE, 0, PC_PLUS4, 1'b1, 1'b0, 5);
        // Loads take a read cycle and a write-back cycle
        add_entry(OPC_LOAD, F3_BYTE, 1'b0, 1, WB_MEM, 1, 0, SIZE_BYTE, 0, PC_PLUS4, 1'b1, 1'b0, 6);
        add_entry(OPC_LOAD, F3_HALF, 1'b0, 1, WB_MEM, 1, 0, SIZE_HALF, 0, PC_PLUS4, 1'b1, 1'b0, 6);
        add_entry(OPC_LOAD, F3_WORD, 1'b0, 1, WB_MEM, 1, 0, SIZE_WORD, 0, PC_PLUS4, 1'b1, 1'b0, 6);
        add_entry(OPC_LOAD, F3_BYTE_U, 1'b0, 1, WB_MEM, 1, 0, SIZE_BYTE, 0, PC_PLUS4, 1'b1, 1'b0, 6);
        add_entry(OPC_LOAD, F3_HALF_U, 1'b0, 1, WB_MEM, 1, 0, SIZE_HALF, 0, PC_PLUS4, 1'b1, 1'b0, 6);
        add_entry(OPC_LOAD, 3'b011, 1'b0, 0, WB_ALU, 0, 0, SIZE_NONE, 0, PC_PLUS4, 1'b0, 1'b0, 5);
        add_entry(OPC_STORE, F3_BYTE, 1'b0, 0, WB_ALU, 0, 1, SIZE_BYTE, 0, PC_PLUS4, 1'b1, 1'b0, 5);
        add_entry(OPC_STORE, F3_HALF, 1'b0, 0, WB_ALU, 0, 1, SIZE_HALF, 0, PC_PLUS4, 1'b1, 1'b0, 5);
        add_entry(OPC_STORE, F3_WORD, 1'b1, 0, WB_ALU, 0, 1, SIZE_WORD, 0, PC_PLUS4, 1'b1, 1'b0, 5);
        // Control transfer
        add_entry(OPC_BRANCH, 3'b000, 1'b1, 0, WB_ALU, 0, 0, SIZE_NONE, 1, PC_BRANCH, 1'b0, 1'b0, 5);
        add_entry(OPC_BRANCH, 3'b001, 1'b0, 0, WB_ALU, 0, 0, SIZE_NONE, 0, PC_PLUS4, 1'b0, 1'b0, 5);
        add_entry(OPC_JAL, 3'b000, 1'b0, 1, WB_PC4, 0, 0, SIZE_NONE, 1, PC_JAL, 1'b0, 1'b0, 5);
        add_entry(OPC_JALR, 3'b000, 1'b1, 1, WB_PC4, 0, 0, SIZE_NONE, 1, PC_JALR, 1'b1, 1'b0, 5);
        // Unsupported opcodes end right after the increment
        add_entry(7'b0000000, 3'b000, 1'b0, 0, WB_ALU, 0, 0, SIZE_NONE, 0, PC_PLUS4, 1'b0, 1'b1, 3);
        add_entry(7'b0001111, 3'b000, 1'b1, 0, WB_ALU, 0, 0, SIZE_NONE, 0, PC_PLUS4, 1'b0, 1'b1, 3);
        add_entry(7'b1111111, 3'b010, 1'b0, 0, WB_ALU, 0, 0, SIZE_NONE, 0, PC_PLUS4, 1'b0, 1'b1, 3);
    endtask

    function automatic ctrl_word_t expected_word(input test_entry_t e);
        ctrl_word_t w;
        w.pc_en     = (e.n_pc_extra > 0);
        w.pc_select = e.pc_select;
        w.alu_src   = e.alu_src;
        w.reg_write = (e.n_reg_write > 0);
        w.wb_sel    = e.wb_sel;
        w.mem_size  = e.mem_size;
        w.mem_read  = (e.n_mem_read > 0);
        w.mem_write = (e.n_mem_write > 0);
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // One instruction from go to instr_done

    task automatic run_entry(input test_entry_t e);
        int         waited;
        ctrl_word_t got;
        @(posedge clk);
        #2;
        opcode     = e.opcode;
        funct3     = e.funct3;
        comparator = e.comparator;
        go         = 1'b1;
        @(posedge clk);                // Sequencer takes go here
        #2;
        go = 1'b0;
        clear_monitor();
        capture = 1'b1;
        waited  = 0;
        while (!done_seen && waited < DONE_TIMEOUT)
        begin
            @(posedge clk);
            waited++;
            if (waited == 3)
            begin
                // Start was sampled at this edge, so the outcome must not follow
                #2;
                comparator = !e.comparator;
            end
        end
        if (!done_seen)
        begin
            timeout_count++;
            $display("Timeout at %0t: entry %0d got no instr_done within %0d cycles",
                     $time, cur_entry, DONE_TIMEOUT);
        end
        else
        begin
            got.pc_en     = (n_pc_extra > 0);
            got.pc_select = seen_pc_sel;
            got.alu_src   = seen_alu_src;
            got.reg_write = (n_reg_write > 0);
            got.wb_sel    = seen_wb_sel;
            got.mem_size  = seen_size;
            got.mem_read  = (n_mem_read > 0);
            got.mem_write = (n_mem_write > 0);
            check_count("ir_en pulses", n_ir_en, 1);
            check_count("ir_en cycle", ir_cycle, 1);
            check_count("PC increment pulses", n_pc_inc, 1);
            check_count("PC increment cycle", inc_cycle, 2);
            check_count("latency", latency, e.cycles);
            check_count("reg_write cycles", n_reg_write, e.n_reg_write);
            check_count("mem_read cycles", n_mem_read, e.n_mem_read);
            check_count("mem_write cycles", n_mem_write, e.n_mem_write);
            check_count("extra pc_en cycles", n_pc_extra, e.n_pc_extra);
            check_count("mem_size without strobe", n_stray_size, 0);
            check_count("illegal outside instr_done", n_stray_illegal, 0);
            check_ctrl("control summary", got, expected_word(e));
            check_flag("illegal at instr_done", illegal_at_done, e.illegal);
        end
    endtask

    initial
    begin
        reset         = 1'b1;
        go            = 1'b0;
        opcode        = '0;
        funct3        = '0;
        comparator    = 1'b0;
        capture       = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        cur_entry     = 0;
        clear_monitor();
        build_table();
        for (int i = 0; i < 16; i++)
            @(posedge clk);
        #2;
        reset = 1'b0;

        for (int i = 0; i < entries.size(); i++)
        begin
            cur_entry = i;
            run_entry(entries[i]);
            if (timeout_count != 0)
                break;
        end

        $display("Done: %0d mismatches, %0d timeouts, %0d entries",
                 error_count, timeout_count, entries.size());
        if (error_count == 0 && timeout_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- controller.f
logic/ctrl_pkg.sv
logic/exec_if.sv
logic/main_sequencer.sv
logic/alu_writeback_fsm.sv
logic/mem_access_fsm.sv
logic/control_transfer_fsm.sv
logic/controller.sv
verification/controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the controller testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module controller_tb \
    -f controller.f -o controller_sim > build.log 2>&1 \
    && ./obj_dir/controller_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Simulation failed" sim.log \
    && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }
